/* compile.f */
+incdir+rtl
rtl/frame_rx_pkg.sv
rtl/miller_sequence_decode.sv
rtl/frame_byte_assembler.sv
rtl/frame_event_output.sv
rtl/frame_rx_top.sv
verif/frame_event_properties.sv
verif/frame_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the frame receive testbench with Verilator and runs it
# the result is taken from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module frame_rx_tb \
    -Mdir obj_dir -o frame_rx_sim > build.log 2>&1 &&
./obj_dir/frame_rx_sim +verilator+error+limit+100 > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test completed successfully" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

/* verif/frame_rx_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frame_rx_config.svh"

module frame_rx_tb;

    localparam int max_rows      = 16;
    localparam int event_timeout = 20;
    localparam int drain_limit   = 200;
    localparam int quiet_cycles  = 8;
    localparam int corr_none     = 0;
    localparam int corr_flip     = 1;
    localparam int corr_invalid  = 2;
    localparam int corr_z        = 3;

    logic                                clk;
    logic                                reset;
    logic                                seq_valid;
    frame_rx_pkg::miller_seq_t           seq;
    logic                                soc;
    logic                                eoc;
    logic [`FRAME_RX_BYTE_BITS-1:0]      data;
    logic [`FRAME_RX_COUNT_WIDTH-1:0]    data_bits;
    logic                                data_valid;
    logic                                sequence_error;
    logic                                parity_error;

    // test table with one row per frame
    string       test_name  [max_rows];
    int          frame_len  [max_rows];
    logic [26:0] frame_bits [max_rows];
    int          corr_kind  [max_rows];
    int          corr_pos   [max_rows];
    int          n_rows = 0;

    // event word is {soc, eoc, data_valid, sequence_error, parity_error, data_bits, data}
    frame_rx_pkg::miller_seq_t seq_q[$];
    logic [15:0]               expected[$];
    logic [31:0]               lfsr_state;
    logic [26:0]               row_bits;
    logic                      drive_done;
    int                        test_errors;
    int                        failed_tests = 0;

    frame_rx_top i_dut (
        .clk            (clk),
        .reset          (reset),
        .seq_valid      (seq_valid),
        .seq            (seq),
        .soc            (soc),
        .eoc            (eoc),
        .data           (data),
        .data_bits      (data_bits),
        .data_valid     (data_valid),
        .sequence_error (sequence_error),
        .parity_error   (parity_error)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // ========================================
    // helpers
    // ========================================

    // right shifting Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // a byte followed by its odd parity bit with the LSB sent first
    function automatic logic [8:0] with_parity(input logic [7:0] b);
        return {~^b, b};
    endfunction

    // three random bytes with one LFSR step per data bit
    function automatic logic [26:0] random_frame();
        logic [26:0] f;
        logic [7:0]  b;
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 8; j++) begin
                lfsr_state = lfsr_step(lfsr_state);
                b[j] = lfsr_state[0];
            end
            f[k*9 +: 9] = with_parity(b);
        end
        return f;
    endfunction

    function automatic logic any_event();
        return soc | eoc | data_valid | sequence_error | parity_error;
    endfunction

    // data is only meaningful while data_valid is high
    function automatic logic [15:0] observed_event();
        return {soc, eoc, data_valid, sequence_error, parity_error, data_bits,
                data_valid ? data : 8'h00};
    endfunction

    task automatic compare_values(input string name, input logic [15:0] want,
                                  input logic [15:0] got);
        if (want !== got) begin
            $display("MISMATCH %s expected %h actual %h", name, want, got);
            test_errors++;
        end
    endtask

    task automatic add_row(input string name, input int len, input logic [26:0] bits,
                           input int kind, input int pos);
        test_name[n_rows]  = name;
        frame_len[n_rows]  = len;
        frame_bits[n_rows] = bits;
        corr_kind[n_rows]  = kind;
        corr_pos[n_rows]   = pos;
        n_rows++;
    endtask

    // ========================================
    // Miller encoder and event model
    // ========================================

    task automatic encode_frame(input logic [26:0] bits, input int len, input int kind,
                                input int pos);
        logic prev;
        seq_q.delete();
        seq_q.push_back(frame_rx_pkg::seq_z);
        // the start of communication counts as a zero for the first bit
        prev = 1'b0;
        for (int i = 0; i < len; i++) begin
            // a broken sequence aborts the frame and nothing follows it
            if (i == pos && kind == corr_invalid) begin
                seq_q.push_back(frame_rx_pkg::seq_invalid);
                return;
            end
            if (i == pos && kind == corr_z) begin
                seq_q.push_back(frame_rx_pkg::seq_z);
                return;
            end
            if (bits[i]) begin
                seq_q.push_back(frame_rx_pkg::seq_x);
            end else begin
                seq_q.push_back(prev ? frame_rx_pkg::seq_y : frame_rx_pkg::seq_z);
            end
            prev = bits[i];
        end
        // end of communication is a logic zero followed by Y
        seq_q.push_back(prev ? frame_rx_pkg::seq_y : frame_rx_pkg::seq_z);
        seq_q.push_back(frame_rx_pkg::seq_y);
    endtask

    task automatic build_expected(input logic [26:0] bits, input int len, input int kind,
                                  input int pos);
        int         n;
        int         cnt;
        logic [7:0] sh;
        logic       par;
        logic       full;
        expected.delete();
        expected.push_back({5'b10000, 11'h000});
        n    = len;
        cnt  = 0;
        sh   = 8'h00;
        par  = 1'b0;
        full = 1'b0;
        // the bit still held in the decoder at the break never arrives
        if (kind == corr_invalid || kind == corr_z) begin
            n = (pos > 0) ? pos - 1 : 0;
        end
        for (int i = 0; i < n; i++) begin
            if (full) begin
                if ((par ^ bits[i]) == 1'b1) begin
                    expected.push_back({5'b00100, 3'd0, sh});
                end else begin
                    // the rest of the frame is dropped silently
                    expected.push_back({5'b00001, 11'h000});
                    return;
                end
                full = 1'b0;
                cnt  = 0;
                par  = 1'b0;
                sh   = 8'h00;
            end else begin
                sh[cnt] = bits[i];
                par     = par ^ bits[i];
                cnt++;
                full = (cnt == 8);
            end
        end
        if (kind == corr_invalid || kind == corr_z) begin
            expected.push_back({5'b00010, 11'h000});
        end else if (full) begin
            expected.push_back({5'b01010, 11'h000});
        end else begin
            expected.push_back({1'b0, 1'b1, cnt != 0, 2'b00, 3'(cnt), sh});
        end
    endtask

    // ========================================
    // driver and checker
    // ========================================

    // one strobe every second cycle
    task automatic drive_sequences();
        foreach (seq_q[i]) begin
            @(posedge clk);
            seq_valid <= 1'b1;
            seq       <= seq_q[i];
            @(posedge clk);
            seq_valid <= 1'b0;
        end
        drive_done = 1'b1;
    endtask

    task automatic check_events(input string name);
        int   waited;
        int   quiet;
        int   guard;
        logic found;
        for (int idx = 0; idx < expected.size(); idx++) begin
            found  = 1'b0;
            waited = 0;
            while (!found && waited < event_timeout) begin
                @(negedge clk);
                waited++;
                found = any_event();
            end
            if (!found) begin
                $display("%s: event %0d did not arrive within %0d cycles", name, idx,
                         event_timeout);
                test_errors++;
                break;
            end
            compare_values(name, expected[idx], observed_event());
        end
        // whatever still comes out before the line goes quiet is unexpected
        quiet = 0;
        guard = 0;
        while (quiet < quiet_cycles && guard < drain_limit) begin
            @(negedge clk);
            guard++;
            if (any_event()) begin
                $display("%s: unexpected event %h", name, observed_event());
                test_errors++;
            end
            quiet = (drive_done && !any_event()) ? quiet + 1 : 0;
        end
        if (quiet < quiet_cycles) begin
            $display("%s: outputs did not go quiet after the frame", name);
            test_errors++;
        end
    endtask

    task automatic run_test(input string name);
        test_errors = 0;
        drive_done  = 1'b0;
        fork
            drive_sequences();
            check_events(name);
        join
        if (test_errors == 0) begin
            $display("%-16s ok", name);
        end else begin
            $display("%-16s FAILED with %0d errors", name, test_errors);
            failed_tests++;
        end
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        reset      = 1'b1;
        seq_valid  = 1'b0;
        seq        = frame_rx_pkg::seq_x;
        lfsr_state = 32'h323e_1dcd;

        add_row("one_byte", 9, 27'(with_parity(8'hA5)), corr_none, 0);
        add_row("zero_bytes", 18, 27'({with_parity(8'h00), with_parity(8'h00)}), corr_none, 0);
        add_row("three_bytes", 27, {with_parity(8'h3C), with_parity(8'hFF), with_parity(8'h81)},
                corr_none, 0);
        add_row("empty_frame", 0, 27'h0, corr_none, 0);
        add_row("short_7bit", 7, 27'h26, corr_none, 0);
        add_row("anticoll_1bit", 1, 27'h1, corr_none, 0);
        add_row("anticoll_6bit", 6, 27'h2D, corr_none, 0);
        add_row("parity_flip", 27, {with_parity(8'hFF), with_parity(8'h00), with_parity(8'hA5)},
                corr_flip, 17);
        add_row("invalid_seq", 18, 27'({with_parity(8'h00), with_parity(8'hA5)}),
                corr_invalid, 12);
        add_row("z_after_one", 9, 27'(with_parity(8'hA5)), corr_z, 3);
        add_row("no_parity", 8, 27'hA5, corr_none, 0);
        for (int k = 0; k < 3; k++) begin
            add_row($sformatf("random_%0d", k), 27, random_frame(), corr_none, 0);
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // idle line noise must not open a frame
        seq_q = '{frame_rx_pkg::seq_y, frame_rx_pkg::seq_x, frame_rx_pkg::seq_invalid,
                  frame_rx_pkg::seq_y, frame_rx_pkg::seq_x};
        expected.delete();
        run_test("idle_noise");

        for (int r = 0; r < n_rows; r++) begin
            row_bits = frame_bits[r];
            if (corr_kind[r] == corr_flip) begin
                row_bits[corr_pos[r]] = ~row_bits[corr_pos[r]];
            end
            encode_frame(row_bits, frame_len[r], corr_kind[r], corr_pos[r]);
            build_expected(row_bits, frame_len[r], corr_kind[r], corr_pos[r]);
            run_test(test_name[r]);
        end

        $display("%0d tests, %0d passed, %0d failed, %0d assertion failures", n_rows + 1,
                 n_rows + 1 - failed_tests, failed_tests, i_dut.i_output.i_properties.failures);
        if (failed_tests == 0 && i_dut.i_output.i_properties.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/frame_event_properties.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frame_rx_config.svh"

module frame_event_properties (
    input logic                                clk,
    input logic                                reset,
    input logic                                soc,
    input logic                                eoc,
    input logic                                data_valid,
    input logic                                sequence_error,
    input logic                                parity_error,
    input logic [`FRAME_RX_BYTE_BITS-1:0]      data,
    input logic [`FRAME_RX_COUNT_WIDTH-1:0]    data_bits
);

    // count of assertion failures over the whole run
    int unsigned failures = 0;

    logic [4:0] flags;

    assign flags = {soc, eoc, data_valid, sequence_error, parity_error};

    // ========================================
    // event output rules
    // ========================================

    // one cycle after a reset edge every output sits at its reset value
    reset_quiet: assert property (@(posedge clk)
        reset |=> (flags == '0) && (data == '0) && (data_bits == '0))
        else begin
            failures++;
            $error("event outputs not cleared during reset");
        end

    // no flag may stay high for two cycles in a row
    single_pulse: assert property (@(posedge clk) disable iff (reset)
        (flags & $past(flags)) == '0)
        else begin
            failures++;
            $error("event flag held for more than one cycle");
        end

    // start and error events never carry data
    no_data_with_control: assert property (@(posedge clk) disable iff (reset)
        !((soc || sequence_error || parity_error) && data_valid))
        else begin
            failures++;
            $error("data_valid raised together with soc or an error");
        end

    // a bit count is only reported for a partial byte at end of frame
    bits_only_at_end: assert property (@(posedge clk) disable iff (reset)
        (data_bits != '0) |-> (eoc && data_valid))
        else begin
            failures++;
            $error("data_bits nonzero outside a partial end of frame");
        end

endmodule

bind frame_event_output frame_event_properties i_properties (
    .clk            (clk),
    .reset          (reset),
    .soc            (soc),
    .eoc            (eoc),
    .data_valid     (data_valid),
    .sequence_error (sequence_error),
    .parity_error   (parity_error),
    .data           (data),
    .data_bits      (data_bits)
);

`default_nettype wire

/* rtl/frame_rx_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frame_rx_config.svh"

module frame_rx_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                seq_valid,
    input  frame_rx_pkg::miller_seq_t           seq,
    output logic                                soc,
    output logic                                eoc,
    output logic [`FRAME_RX_BYTE_BITS-1:0]      data,
    output logic [`FRAME_RX_COUNT_WIDTH-1:0]    data_bits,
    output logic                                data_valid,
    output logic                                sequence_error,
    output logic                                parity_error
);

    // ========================================
    // stage to stage links
    // ========================================

    // decode to assembler
    logic                                sym_valid;
    frame_rx_pkg::frame_sym_t            sym;

    // assembler to output stage, one flag at a time apart from eoc
    // with an unterminated byte
    logic                                ev_soc;
    logic                                ev_eoc;
    logic                                ev_byte;
    logic                                ev_parity_error;
    logic                                ev_sequence_error;
    logic [`FRAME_RX_BYTE_BITS-1:0]      ev_data;
    logic [`FRAME_RX_COUNT_WIDTH-1:0]    ev_bits;

    // Miller sequences to bits
    miller_sequence_decode i_decode (
        .clk       (clk),
        .reset     (reset),
        .seq_valid (seq_valid),
        .seq       (seq),
        .sym_valid (sym_valid),
        .sym       (sym)
    );

    // bits to bytes with parity
    frame_byte_assembler i_assembler (
        .clk               (clk),
        .reset             (reset),
        .sym_valid         (sym_valid),
        .sym               (sym),
        .ev_soc            (ev_soc),
        .ev_eoc            (ev_eoc),
        .ev_byte           (ev_byte),
        .ev_parity_error   (ev_parity_error),
        .ev_sequence_error (ev_sequence_error),
        .ev_data           (ev_data),
        .ev_bits           (ev_bits)
    );

    // registered frame events
    frame_event_output i_output (
        .clk               (clk),
        .reset             (reset),
        .ev_soc            (ev_soc),
        .ev_eoc            (ev_eoc),
        .ev_byte           (ev_byte),
        .ev_parity_error   (ev_parity_error),
        .ev_sequence_error (ev_sequence_error),
        .ev_data           (ev_data),
        .ev_bits           (ev_bits),
        .soc               (soc),
        .eoc               (eoc),
        .data_valid        (data_valid),
        .sequence_error    (sequence_error),
        .parity_error      (parity_error),
        .data              (data),
        .data_bits         (data_bits)
    );

endmodule

`default_nettype wire

/* rtl/frame_event_output.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frame_rx_config.svh"

module frame_event_output (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ev_soc,
    input  logic                                ev_eoc,
    input  logic                                ev_byte,
    input  logic                                ev_parity_error,
    input  logic                                ev_sequence_error,
    input  logic [`FRAME_RX_BYTE_BITS-1:0]      ev_data,
    input  logic [`FRAME_RX_COUNT_WIDTH-1:0]    ev_bits,
    output logic                                soc,
    output logic                                eoc,
    output logic                                data_valid,
    output logic                                sequence_error,
    output logic                                parity_error,
    output logic [`FRAME_RX_BYTE_BITS-1:0]      data,
    output logic [`FRAME_RX_COUNT_WIDTH-1:0]    data_bits
);

    logic partial_eoc;
    logic data_event;

    // end of frame carrying a short or anticollision remainder
    // ev_bits is only looked at while ev_eoc is high
    assign partial_eoc = ev_eoc && !ev_sequence_error && (ev_bits != '0);
    // either a whole checked byte or the remainder above
    assign data_event  = ev_byte || partial_eoc;

    // ========================================
    // registered event outputs
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            soc            <= 1'b0;
            eoc            <= 1'b0;
            data_valid     <= 1'b0;
            sequence_error <= 1'b0;
            parity_error   <= 1'b0;
            data           <= '0;
            data_bits      <= '0;
        end else begin
            soc            <= ev_soc;
            eoc            <= ev_eoc;
            sequence_error <= ev_sequence_error;
            parity_error   <= ev_parity_error;
            data_valid     <= data_event;

            // a full byte reports zero here, as does every non-data cycle
            if (partial_eoc) begin
                data_bits <= ev_bits;
            end else begin
                data_bits <= '0;
            end

            // data keeps the last byte until the next data event
            if (data_event) begin
                data <= ev_data;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_byte_assembler.sv */
`timescale 1ns/1ns
`default_nettype none

`include "frame_rx_config.svh"

module frame_byte_assembler (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                sym_valid,
    input  frame_rx_pkg::frame_sym_t            sym,
    output logic                                ev_soc,
    output logic                                ev_eoc,
    output logic                                ev_byte,
    output logic                                ev_parity_error,
    output logic                                ev_sequence_error,
    output logic [`FRAME_RX_BYTE_BITS-1:0]      ev_data,
    output logic [`FRAME_RX_COUNT_WIDTH-1:0]    ev_bits
);

    // index of the last data bit, after it the parity bit follows
    localparam int unsigned last_index = `FRAME_RX_BYTE_BITS - 1;

    logic [`FRAME_RX_BYTE_BITS-1:0]   shift_data;
    logic [`FRAME_RX_COUNT_WIDTH-1:0] bit_count;
    logic                             byte_full;
    logic                             parity_acc;
    logic                             abandoned;
    logic                             accept;
    logic                             is_bit;
    logic                             bit_value;
    logic                             parity_ok;

    // after a parity error only a new start is taken
    assign accept    = sym_valid && (!abandoned || sym == frame_rx_pkg::sym_soc);
    assign is_bit    = (sym == frame_rx_pkg::sym_zero) || (sym == frame_rx_pkg::sym_one);
    assign bit_value = (sym == frame_rx_pkg::sym_one);
    // odd parity: the eight data bits and the parity bit xor to one
    assign parity_ok = parity_acc ^ bit_value;

    // ========================================
    // control and event flags
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            ev_soc            <= 1'b0;
            ev_eoc            <= 1'b0;
            ev_byte           <= 1'b0;
            ev_parity_error   <= 1'b0;
            ev_sequence_error <= 1'b0;
            bit_count         <= '0;
            byte_full         <= 1'b0;
            parity_acc        <= 1'b0;
            abandoned         <= 1'b0;
        end else begin
            ev_soc            <= 1'b0;
            ev_eoc            <= 1'b0;
            ev_byte           <= 1'b0;
            ev_parity_error   <= 1'b0;
            ev_sequence_error <= 1'b0;

            if (accept) begin
                case (sym)
                    frame_rx_pkg::sym_soc: begin
                        ev_soc     <= 1'b1;
                        bit_count  <= '0;
                        byte_full  <= 1'b0;
                        parity_acc <= 1'b0;
                        abandoned  <= 1'b0;
                    end
                    frame_rx_pkg::sym_zero, frame_rx_pkg::sym_one: begin
                        if (byte_full) begin
                            // this is the ninth bit, the parity of the byte
                            byte_full  <= 1'b0;
                            parity_acc <= 1'b0;
                            if (parity_ok) begin
                                ev_byte <= 1'b1;
                            end else begin
                                ev_parity_error <= 1'b1;
                                abandoned       <= 1'b1;
                            end
                        end else begin
                            // the count wraps to zero as the byte fills
                            bit_count  <= bit_count + 1'b1;
                            parity_acc <= parity_acc ^ bit_value;
                            if (bit_count == `FRAME_RX_COUNT_WIDTH'(last_index)) begin
                                byte_full <= 1'b1;
                            end
                        end
                    end
                    frame_rx_pkg::sym_eoc: begin
                        // a full byte without its parity bit is a broken frame
                        ev_eoc            <= 1'b1;
                        ev_sequence_error <= byte_full;
                    end
                    frame_rx_pkg::sym_seq_error: begin
                        ev_sequence_error <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // ========================================
    // byte payload
    // ========================================

    // bits land at their own index, so a partial byte is already
    // right aligned with zeros above it
    always_ff @(posedge clk) begin
        if (accept) begin
            if (sym == frame_rx_pkg::sym_soc) begin
                shift_data <= '0;
            end else if (is_bit) begin
                if (byte_full) begin
                    ev_data    <= shift_data;
                    shift_data <= '0;
                end else begin
                    shift_data[bit_count] <= bit_value;
                end
            end else if (sym == frame_rx_pkg::sym_eoc) begin
                ev_data <= shift_data;
                ev_bits <= bit_count;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/miller_sequence_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module miller_sequence_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    seq_valid,
    input  frame_rx_pkg::miller_seq_t seq,
    output logic                    sym_valid,
    output frame_rx_pkg::frame_sym_t  sym
);

    // the latest bit is always held back by one sequence
    // a zero followed by Y is the end pattern and must not reach the assembler
    typedef enum logic [1:0] {
        st_idle,
        st_held_start,
        st_held_zero,
        st_held_one
    } decode_state_t;

    decode_state_t            state;
    decode_state_t            next_state;
    logic                     emit;
    frame_rx_pkg::frame_sym_t emit_sym;

    // ========================================
    // next state and symbol
    // ========================================

    always_comb begin
        next_state = state;
        emit       = 1'b0;
        emit_sym   = frame_rx_pkg::sym_zero;

        if (seq_valid) begin
            case (state)
                // only Z opens a frame, everything else is line noise
                st_idle: begin
                    if (seq == frame_rx_pkg::seq_z) begin
                        emit       = 1'b1;
                        emit_sym   = frame_rx_pkg::sym_soc;
                        next_state = st_held_start;
                    end
                end

                // after SOC nothing is held, after a zero the zero is held
                st_held_start, st_held_zero: begin
                    case (seq)
                        frame_rx_pkg::seq_x: begin
                            emit       = (state == st_held_zero);
                            emit_sym   = frame_rx_pkg::sym_zero;
                            next_state = st_held_one;
                        end
                        frame_rx_pkg::seq_z: begin
                            emit       = (state == st_held_zero);
                            emit_sym   = frame_rx_pkg::sym_zero;
                            next_state = st_held_zero;
                        end
                        frame_rx_pkg::seq_y: begin
                            // held zero plus Y is end of communication
                            // so the held zero is dropped here
                            emit       = 1'b1;
                            emit_sym   = frame_rx_pkg::sym_eoc;
                            next_state = st_idle;
                        end
                        default: begin
                            emit       = 1'b1;
                            emit_sym   = frame_rx_pkg::sym_seq_error;
                            next_state = st_idle;
                        end
                    endcase
                end

                // a one is held, a zero after it is sent as Y
                st_held_one: begin
                    case (seq)
                        frame_rx_pkg::seq_x: begin
                            emit       = 1'b1;
                            emit_sym   = frame_rx_pkg::sym_one;
                            next_state = st_held_one;
                        end
                        frame_rx_pkg::seq_y: begin
                            emit       = 1'b1;
                            emit_sym   = frame_rx_pkg::sym_one;
                            next_state = st_held_zero;
                        end
                        default: begin
                            // Z after a one is not a legal Miller sequence
                            emit       = 1'b1;
                            emit_sym   = frame_rx_pkg::sym_seq_error;
                            next_state = st_idle;
                        end
                    endcase
                end

                default: begin
                    next_state = st_idle;
                end
            endcase
        end
    end

    // ========================================
    // registers
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= st_idle;
            sym_valid <= 1'b0;
        end else begin
            state     <= next_state;
            sym_valid <= emit;
        end
    end

    // symbol payload only changes when a new one is issued
    always_ff @(posedge clk) begin
        if (emit) begin
            sym <= emit_sym;
        end
    end

endmodule

`default_nettype wire

/* rtl/frame_rx_pkg.sv */
`default_nettype none

package frame_rx_pkg;

    // ========================================
    // input sequence classes
    // ========================================

    // classified modified-Miller sequence for one bit period
    // seq_invalid covers any pause pattern that is none of X, Y or Z
    typedef enum logic [1:0] {
        seq_x,
        seq_y,
        seq_z,
        seq_invalid
    } miller_seq_t;

    // ========================================
    // decoded symbols
    // ========================================

    // what the decode stage hands to the byte assembler
    // sym_eoc and sym_seq_error both end the current frame
    typedef enum logic [2:0] {
        sym_soc,
        sym_zero,
        sym_one,
        sym_eoc,
        sym_seq_error
    } frame_sym_t;

endpackage

`default_nettype wire

/* rtl/frame_rx_config.svh */
`ifndef FRAME_RX_CONFIG_SVH
`define FRAME_RX_CONFIG_SVH

// ========================================
// frame receive path sizing
// ========================================

// number of data bits in one received byte, parity not included
`define FRAME_RX_BYTE_BITS 8

// width of the partial-bit count reported at end of frame
// it also indexes the bits of a byte as they are collected
`define FRAME_RX_COUNT_WIDTH 3

`endif
